// ==== rtl/ecc_pkg.sv ====
// hsiao secded code widths, parity-check column table and decode result type
`default_nettype none

package ecc_pkg;

    // ========================================
    // code geometry
    // ========================================
    localparam int unsigned DATA_W  = 32;
    localparam int unsigned CHECK_W = 7;
    localparam int unsigned CODE_W  = DATA_W + CHECK_W;  // 39 bits per stored lane

    // ========================================
    // parity-check matrix, one column per codeword bit
    // ========================================
    // entries 0 to 31 are the data bits and take the first 32 weight-3 columns
    // entries 32 to 38 are the check bits and take the weight-1 columns
    // every column is odd and distinct, so any single flip gives an odd syndrome
    localparam logic [CHECK_W-1:0] HSIAO_COLS [CODE_W] = '{
        7'b0000111,
        7'b0001011,
        7'b0001101,
        7'b0001110,
        7'b0010011,
        7'b0010101,
        7'b0010110,
        7'b0011001,
        7'b0011010,
        7'b0011100,
        7'b0100011,
        7'b0100101,
        7'b0100110,
        7'b0101001,
        7'b0101010,
        7'b0101100,
        7'b0110001,
        7'b0110010,
        7'b0110100,
        7'b0111000,
        7'b1000011,
        7'b1000101,
        7'b1000110,
        7'b1001001,
        7'b1001010,
        7'b1001100,
        7'b1010001,
        7'b1010010,
        7'b1010100,
        7'b1011000,
        7'b1100001,
        7'b1100010,  // last data column
        7'b0000001,  // check bit 0
        7'b0000010,
        7'b0000100,
        7'b0001000,
        7'b0010000,
        7'b0100000,
        7'b1000000
    };

    // outcome of decoding one lane
    typedef enum logic [1:0] {
        ECC_OK,
        ECC_CORRECTED,
        ECC_UNCORRECTABLE
    } ecc_result_e;

endpackage

`default_nettype wire

// ==== rtl/sram_pkg.sv ====
// memory geometry plus the request, error-injection and error-status structs
`default_nettype none

package sram_pkg;

    localparam int unsigned ADDR_W = 6;
    localparam int unsigned DEPTH  = 2**ADDR_W;  // 64 words
    localparam int unsigned NLANES = 2;

    // one access per cycle, the strobe is cs and the direction is we
    typedef struct packed {
        logic                                   cs;
        logic                                   we;
        logic [ADDR_W-1:0]                      addr;
        logic [NLANES-1:0][ecc_pkg::DATA_W-1:0] wdata;
        logic [NLANES-1:0][ecc_pkg::DATA_W-1:0] wmask;
    } sram_req_t;

    // bits set in msk get flipped in the stored data while en is high
    typedef struct packed {
        logic                                   en;
        logic [NLANES-1:0][ecc_pkg::DATA_W-1:0] msk;
    } err_inj_t;

    typedef struct packed {
        logic [NLANES-1:0] cor;  // single-bit error fixed on that lane
        logic [NLANES-1:0] unc;  // data on that lane cannot be trusted
    } ecc_status_t;

endpackage

`default_nettype wire

// ==== rtl/ecc_enc.sv ====
// hsiao secded encoder for one 32-bit lane
`timescale 1ns/1ns
`default_nettype none

module ecc_enc (
    input  wire logic [ecc_pkg::DATA_W-1:0] data,
    output logic [ecc_pkg::CODE_W-1:0]      code
);

    logic [ecc_pkg::CHECK_W-1:0] check;

    // each data bit folds its column into the check bits, which gives
    // every check bit the parity of the data bits that have it set
    always_comb begin
        check = '0;
        for (int i = 0; i < ecc_pkg::DATA_W; i++) begin
            if (data[i]) begin
                check = check ^ ecc_pkg::HSIAO_COLS[i];
            end
        end
    end

    assign code = {check, data};  // check bits sit above the data

endmodule

`default_nettype wire

// ==== rtl/ecc_dec.sv ====
// hsiao secded decoder for one 39-bit codeword with single-bit correction
`timescale 1ns/1ns
`default_nettype none

module ecc_dec (
    input  wire logic [ecc_pkg::CODE_W-1:0] code,
    output logic [ecc_pkg::DATA_W-1:0]      data,
    output ecc_pkg::ecc_result_e            result
);

    logic [ecc_pkg::CHECK_W-1:0] synd;
    logic [ecc_pkg::DATA_W-1:0]  flip;

    // the check bits have weight-one columns, so folding the whole codeword
    // gives stored check bits xor recomputed parity in a single pass
    always_comb begin
        synd = '0;
        for (int j = 0; j < ecc_pkg::CODE_W; j++) begin
            if (code[j]) begin
                synd = synd ^ ecc_pkg::HSIAO_COLS[j];
            end
        end
    end

    // ========================================
    // classify the syndrome
    // ========================================
    always_comb begin
        flip   = '0;
        result = ecc_pkg::ECC_OK;
        if (synd != '0) begin
            result = ecc_pkg::ECC_UNCORRECTABLE;  // even weight or no matching column
            if (^synd) begin
                for (int j = 0; j < ecc_pkg::DATA_W; j++) begin
                    if (synd == ecc_pkg::HSIAO_COLS[j]) begin
                        flip[j] = 1'b1;
                        result  = ecc_pkg::ECC_CORRECTED;
                    end
                end
                // a flipped check bit leaves the data intact
                for (int j = ecc_pkg::DATA_W; j < ecc_pkg::CODE_W; j++) begin
                    if (synd == ecc_pkg::HSIAO_COLS[j]) begin
                        result = ecc_pkg::ECC_CORRECTED;
                    end
                end
            end
        end
    end

    // flip stays zero unless exactly one column matched
    assign data = code[ecc_pkg::DATA_W-1:0] ^ flip;

endmodule

`default_nettype wire

// ==== rtl/sram_wmask_1rw.sv ====
// behavioral 1rw sram of codeword lanes with bit-wise write mask
`timescale 1ns/1ns
`default_nettype none

module sram_wmask_1rw (
    input  wire logic                                               clk,
    input  wire logic                                               rst,
    input  wire logic                                               cs,
    input  wire logic                                               we,
    input  wire logic [sram_pkg::ADDR_W-1:0]                        addr,
    input  wire logic [sram_pkg::NLANES-1:0][ecc_pkg::CODE_W-1:0]   wdata,
    input  wire logic [sram_pkg::NLANES-1:0][ecc_pkg::CODE_W-1:0]   wmask,
    output logic [sram_pkg::NLANES-1:0][ecc_pkg::CODE_W-1:0]        rdata
);

    logic [sram_pkg::NLANES-1:0][ecc_pkg::CODE_W-1:0] mem [sram_pkg::DEPTH];

    // only the masked bits of the entry change, the rest keep their value
    always_ff @(posedge clk) begin
        if (cs && we) begin
            mem[addr] <= (mem[addr] & ~wmask) | (wdata & wmask);
        end
    end

    // read port holds its word until the next read
    always_ff @(posedge clk) begin
        if (rst) begin
            rdata <= '0;  // all-zero codeword decodes clean
        end else if (cs && !we) begin
            rdata <= mem[addr];
        end
    end

endmodule

`default_nettype wire

// ==== rtl/sram_wmask_ecc_1rw.sv ====
// ecc-protected 1rw sram with per-lane encode, decode and error injection
`timescale 1ns/1ns
`default_nettype none

module sram_wmask_ecc_1rw (
    input  wire logic                                             clk,
    input  wire logic                                             rst,
    input  wire sram_pkg::sram_req_t                              req,
    input  wire sram_pkg::err_inj_t                               inj,
    output logic [sram_pkg::NLANES-1:0][ecc_pkg::DATA_W-1:0]      rdata,
    output sram_pkg::ecc_status_t                                 status
);

    logic [sram_pkg::NLANES-1:0][ecc_pkg::CODE_W-1:0] enc_code;
    logic [sram_pkg::NLANES-1:0][ecc_pkg::CODE_W-1:0] wdata_ecc;
    logic [sram_pkg::NLANES-1:0][ecc_pkg::CODE_W-1:0] wmask_ecc;
    logic [sram_pkg::NLANES-1:0][ecc_pkg::CODE_W-1:0] rdata_ecc;
    ecc_pkg::ecc_result_e                             result [sram_pkg::NLANES];

    sram_wmask_1rw i_sram (
        .clk   (clk),
        .rst   (rst),
        .cs    (req.cs),
        .we    (req.we),
        .addr  (req.addr),
        .wdata (wdata_ecc),
        .wmask (wmask_ecc),
        .rdata (rdata_ecc)
    );

    // ========================================
    // per-lane encode and decode
    // ========================================
    for (genvar i = 0; i < sram_pkg::NLANES; i++) begin : gen_lane
        ecc_enc i_enc (
            .data (req.wdata[i]),
            .code (enc_code[i])
        );

        // injected flips land on the data part only, the check bits stay as encoded
        assign wdata_ecc[i] = enc_code[i] ^
                              {{ecc_pkg::CHECK_W{1'b0}}, inj.msk[i] & {ecc_pkg::DATA_W{inj.en}}};

        // check bits are computed from the whole lane, so they follow its top mask bit
        assign wmask_ecc[i] = {{ecc_pkg::CHECK_W{req.wmask[i][ecc_pkg::DATA_W-1]}},
                               req.wmask[i]};

        ecc_dec i_dec (
            .code   (rdata_ecc[i]),
            .data   (rdata[i]),
            .result (result[i])
        );

        assign status.cor[i] = (result[i] == ecc_pkg::ECC_CORRECTED);
        assign status.unc[i] = (result[i] == ecc_pkg::ECC_UNCORRECTABLE);
    end

endmodule

`default_nettype wire

// ==== rtl/ecc_err_log.sv ====
// error logger with saturating corrected and uncorrectable counters and last error address
`timescale 1ns/1ns
`default_nettype none

module ecc_err_log (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire sram_pkg::sram_req_t     req,
    input  wire sram_pkg::ecc_status_t   status,
    input  wire logic                    err_clr,
    output logic [15:0]                  cnt_cor,
    output logic [15:0]                  cnt_unc,
    output logic [sram_pkg::ADDR_W-1:0]  err_addr
);

    logic                        rd_vld;  // status belongs to a read this cycle
    logic [sram_pkg::ADDR_W-1:0] rd_addr;
    logic                        hit_cor;
    logic                        hit_unc;

    // ========================================
    // track the read whose data comes back now
    // ========================================
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_vld <= 1'b0;
        end else begin
            rd_vld <= req.cs && !req.we;
        end
    end

    always_ff @(posedge clk) begin
        rd_addr <= req.addr;
    end

    assign hit_cor = rd_vld && (|status.cor);
    assign hit_unc = rd_vld && (|status.unc);

    // ========================================
    // counters and address capture
    // ========================================
    always_ff @(posedge clk) begin
        if (rst || err_clr) begin
            cnt_cor <= '0;  // clear wins over an increment in the same cycle
            cnt_unc <= '0;
        end else begin
            if (hit_cor && cnt_cor != '1) cnt_cor <= cnt_cor + 16'd1;
            if (hit_unc && cnt_unc != '1) cnt_unc <= cnt_unc + 16'd1;
        end
    end

    // the address survives err_clr so the last failing word stays visible
    always_ff @(posedge clk) begin
        if (rst) begin
            err_addr <= '0;
        end else if (hit_cor || hit_unc) begin
            err_addr <= rd_addr;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/sram_ecc_top.sv ====
// top level joining the ecc sram and its error logger
`timescale 1ns/1ns
`default_nettype none

module sram_ecc_top (
    input  wire logic                                          clk,
    input  wire logic                                          rst,
    input  wire sram_pkg::sram_req_t                           req,
    input  wire sram_pkg::err_inj_t                            inj,
    input  wire logic                                          err_clr,
    output logic [sram_pkg::NLANES-1:0][ecc_pkg::DATA_W-1:0]   rdata,
    output sram_pkg::ecc_status_t                              status,
    output logic [15:0]                                        cnt_cor,
    output logic [15:0]                                        cnt_unc,
    output logic [sram_pkg::ADDR_W-1:0]                        err_addr
);

    // ========================================
    // data path with read data one cycle after the strobe
    // ========================================
    sram_wmask_ecc_1rw i_sram_ecc (
        .clk    (clk),
        .rst    (rst),
        .req    (req),
        .inj    (inj),
        .rdata  (rdata),
        .status (status)
    );

    // ========================================
    // error logging with counters that move two cycles after the strobe
    // ========================================
    ecc_err_log i_err_log (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .status   (status),
        .err_clr  (err_clr),
        .cnt_cor  (cnt_cor),
        .cnt_unc  (cnt_unc),
        .err_addr (err_addr)
    );

endmodule

`default_nettype wire

// ==== tb/tb_sram_ecc_checker.sv ====
// concurrent assertions on the ecc status flags and the error counters
`timescale 1ns/1ns
`default_nettype none

module tb_sram_ecc_checker (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  err_clr,
    input  wire sram_pkg::ecc_status_t status,
    input  wire logic [15:0]           cnt_cor,
    input  wire logic [15:0]           cnt_unc
);

    int fail_cnt = 0;  // number of assertion failures seen so far

    // a lane is either corrected or uncorrectable, never both
    a_flags_exclusive : assert property (@(posedge clk) disable iff (rst)
        (status.cor & status.unc) == '0)
    else begin
        fail_cnt++;
        $error("cor and unc are both high on one lane");
    end

    // ========================================
    // counters
    // ========================================
    a_cnt_monotonic : assert property (@(posedge clk) disable iff (rst)
        !$past(err_clr) |-> (cnt_cor >= $past(cnt_cor) && cnt_unc >= $past(cnt_unc)))
    else begin
        fail_cnt++;
        $error("an error counter went down without err_clr");
    end

    a_cnt_cleared : assert property (@(posedge clk) disable iff (rst)
        err_clr |=> (cnt_cor == '0 && cnt_unc == '0))
    else begin
        fail_cnt++;
        $error("error counters are not zero after err_clr");
    end

endmodule

`default_nettype wire

// ==== tb/tb_sram_ecc_monitor.sv ====
// testbench monitor with shadow memory, logger model, reference function and compares
`timescale 1ns/1ns
`default_nettype none

module tb_sram_ecc_monitor (
    input  wire logic                                             clk,
    input  wire logic                                             rst,
    input  wire sram_pkg::sram_req_t                              req,
    input  wire sram_pkg::err_inj_t                               inj,
    input  wire logic                                             err_clr,
    input  wire logic [sram_pkg::NLANES-1:0][ecc_pkg::DATA_W-1:0] rdata,
    input  wire sram_pkg::ecc_status_t                            status,
    input  wire logic [15:0]                                      cnt_cor,
    input  wire logic [15:0]                                      cnt_unc,
    input  wire logic [sram_pkg::ADDR_W-1:0]                      err_addr,
    output int                                                    err_cnt,
    output logic                                                  idle
);

    typedef struct packed {
        logic [ecc_pkg::DATA_W-1:0] data;
        logic                       cor;
        logic                       unc;
    } lane_exp_t;

    logic [ecc_pkg::DATA_W-1:0]  shadow [sram_pkg::DEPTH][sram_pkg::NLANES];  // clean data
    int                          flips [sram_pkg::DEPTH][sram_pkg::NLANES];
    logic                        known [sram_pkg::DEPTH][sram_pkg::NLANES] = '{default: 1'b0};
    lane_exp_t                   exp_lane [sram_pkg::NLANES];
    logic                        exp_known [sram_pkg::NLANES];
    logic                        rd_pend;  // read data is on the port this cycle
    logic                        cnt_chk;  // counters moved on the last edge
    logic [sram_pkg::ADDR_W-1:0] rd_addr;
    logic [15:0]                 exp_cor;
    logic [15:0]                 exp_unc;
    logic [sram_pkg::ADDR_W-1:0] exp_addr;
    int                          errs = 0;

    assign err_cnt = errs;
    assign idle    = !rd_pend && !cnt_chk;

    // the number of injected flips decides the class of a lane
    function automatic lane_exp_t expect_lane(input logic [ecc_pkg::DATA_W-1:0] clean,
                                              input int nflip);
        lane_exp_t e;
        e.data = clean;
        e.cor  = (nflip == 1);
        e.unc  = (nflip == 2);
        return e;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] exp_val,
                                 input logic [31:0] act_val);
        if (act_val !== exp_val) begin
            $display("[FAIL] t=%0t %s: expected %0h, actual %0h", $time, name, exp_val, act_val);
            errs++;
        end
    endtask

    // ========================================
    // model update on the rising edge
    // ========================================
    always @(posedge clk) begin
        logic any_cor;
        logic any_unc;
        any_cor = 1'b0;
        any_unc = 1'b0;
        if (rst) begin
            rd_pend  = 1'b0;
            cnt_chk  = 1'b0;
            exp_cor  = '0;
            exp_unc  = '0;
            exp_addr = '0;
        end else begin
            for (int l = 0; l < sram_pkg::NLANES; l++) begin
                if (rd_pend && exp_known[l]) begin
                    any_cor = any_cor | exp_lane[l].cor;
                    any_unc = any_unc | exp_lane[l].unc;
                end
            end
            if (err_clr) begin
                exp_cor = '0;  // clear beats the increment on the same edge
                exp_unc = '0;
            end else begin
                if (any_cor && exp_cor != 16'hffff) exp_cor = exp_cor + 16'd1;
                if (any_unc && exp_unc != 16'hffff) exp_unc = exp_unc + 16'd1;
            end
            if (any_cor || any_unc) exp_addr = rd_addr;
            cnt_chk = rd_pend || err_clr;
            rd_pend = req.cs && !req.we;
            if (rd_pend) begin
                rd_addr = req.addr;
                for (int l = 0; l < sram_pkg::NLANES; l++) begin
                    exp_lane[l]  = expect_lane(shadow[req.addr][l], flips[req.addr][l]);
                    exp_known[l] = known[req.addr][l];
                end
            end
        end
        if (req.cs && req.we) begin
            for (int l = 0; l < sram_pkg::NLANES; l++) begin
                if (req.wmask[l] == '1) begin
                    shadow[req.addr][l] = req.wdata[l];
                    flips[req.addr][l]  = inj.en ? $countones(inj.msk[l]) : 0;
                    known[req.addr][l]  = 1'b1;
                end else if (req.wmask[l] != '0) begin
                    known[req.addr][l] = 1'b0;  // partial mask leaves stale check bits
                end
            end
        end
    end

    // ========================================
    // compares on the falling edge
    // ========================================
    always @(negedge clk) begin
        if (!rst && rd_pend) begin
            for (int l = 0; l < sram_pkg::NLANES; l++) begin
                if (exp_known[l]) begin
                    compare_value($sformatf("status.cor[%0d]", l),
                                  32'(exp_lane[l].cor), 32'(status.cor[l]));
                    compare_value($sformatf("status.unc[%0d]", l),
                                  32'(exp_lane[l].unc), 32'(status.unc[l]));
                    if (!exp_lane[l].unc) begin
                        compare_value($sformatf("rdata[%0d]", l), exp_lane[l].data, rdata[l]);
                    end
                end
            end
        end
        if (!rst && cnt_chk) begin
            compare_value("cnt_cor", 32'(exp_cor), 32'(cnt_cor));
            compare_value("cnt_unc", 32'(exp_unc), 32'(cnt_unc));
            compare_value("err_addr", 32'(exp_addr), 32'(err_addr));
        end
    end

endmodule

`default_nettype wire

// ==== tb/tb_sram_ecc_top.sv ====
// testbench top with clock, reset, stimulus, dut and monitor instances, checker bind and report
`timescale 1ns/1ns
`default_nettype none

module tb_sram_ecc_top;

    typedef logic [sram_pkg::NLANES-1:0][ecc_pkg::DATA_W-1:0] lanes_t;

    logic                        clk = 1'b0;
    logic                        rst;
    sram_pkg::sram_req_t         req;
    sram_pkg::err_inj_t          inj;
    logic                        err_clr;
    lanes_t                      rdata;
    sram_pkg::ecc_status_t       status;
    logic [15:0]                 cnt_cor;
    logic [15:0]                 cnt_unc;
    logic [sram_pkg::ADDR_W-1:0] err_addr;
    int                          mon_errors;
    logic                        mon_idle;
    int                          timeouts = 0;

    always #5 clk = ~clk;

    sram_ecc_top i_dut (.*);

    tb_sram_ecc_monitor i_monitor (
        .*,
        .err_cnt (mon_errors),
        .idle    (mon_idle)
    );

    bind sram_ecc_top tb_sram_ecc_checker i_checker (
        .clk     (clk),
        .rst     (rst),
        .err_clr (err_clr),
        .status  (status),
        .cnt_cor (cnt_cor),
        .cnt_unc (cnt_unc)
    );

    // inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic write_word(input logic [sram_pkg::ADDR_W-1:0] addr, input lanes_t data,
                              input lanes_t mask, input lanes_t flips);
        req.cs    = 1'b1;
        req.we    = 1'b1;
        req.addr  = addr;
        req.wdata = data;
        req.wmask = mask;
        inj.en    = (flips != '0);
        inj.msk   = flips;
        next_cycle();
        req.cs    = 1'b0;
        req.we    = 1'b0;
        inj       = '0;
    endtask

    task automatic read_word(input logic [sram_pkg::ADDR_W-1:0] addr);
        req.cs   = 1'b1;
        req.we   = 1'b0;
        req.addr = addr;
        next_cycle();
        req.cs   = 1'b0;
    endtask

    task automatic clear_counters();
        err_clr = 1'b1;
        next_cycle();
        err_clr = 1'b0;
    endtask

    task automatic wait_idle(input int limit);
        int n;
        n = 0;
        while (!mon_idle && n < limit) begin
            next_cycle();
            n++;
        end
        if (!mon_idle) begin
            $display("timeout: reads still outstanding after %0d cycles", limit);
            timeouts++;
        end
    endtask

    function automatic lanes_t rand_lanes();
        return {$urandom, $urandom};
    endfunction

    function automatic logic [sram_pkg::ADDR_W-1:0] rand_addr();
        logic [31:0] r;
        r = $urandom;
        return r[sram_pkg::ADDR_W-1:0];
    endfunction

    initial begin
        lanes_t                      mask;
        lanes_t                      flips;
        logic [sram_pkg::ADDR_W-1:0] addr;
        int                          b0;
        int                          b1;
        int                          chk_fails;
        b0      = $urandom(90576);  // one seed for the whole run
        rst     = 1'b1;
        err_clr = 1'b0;
        req     = '0;
        inj     = '0;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;

        // ========================================
        // clean fill of every word, then random readback
        // ========================================
        for (int i = 0; i < sram_pkg::DEPTH; i++) begin
            write_word(i[sram_pkg::ADDR_W-1:0], rand_lanes(), '1, '0);
        end
        repeat (20) read_word(rand_addr());

        // a lane with its mask off keeps the old data
        addr    = rand_addr();
        mask    = '0;
        mask[0] = '1;
        write_word(addr, rand_lanes(), mask, '0);
        read_word(addr);
        write_word(addr, rand_lanes(), ~mask, '0);
        read_word(addr);
        wait_idle(20);

        // ========================================
        // single and double flips
        // ========================================
        for (int k = 0; k < 4; k++) begin
            addr  = rand_addr();
            flips = '0;
            flips[k % 2][$urandom % 32] = 1'b1;
            write_word(addr, rand_lanes(), '1, flips);
            read_word(addr);
            read_word(addr);  // each read counts again
        end
        for (int k = 0; k < 2; k++) begin
            addr  = rand_addr();
            b0    = $urandom % 32;
            b1    = (b0 + 1 + $urandom % 31) % 32;
            flips = '0;
            flips[k][b0] = 1'b1;
            flips[k][b1] = 1'b1;
            write_word(addr, rand_lanes(), '1, flips);
            read_word(addr);
            write_word(addr, rand_lanes(), '1, '0);
            read_word(addr);
        end
        wait_idle(20);

        // clear, then a clear on the same edge as a logger update
        clear_counters();
        addr  = rand_addr();
        flips = '0;
        flips[1][$urandom % 32] = 1'b1;
        write_word(addr, rand_lanes(), '1, flips);
        read_word(addr);
        read_word(addr);
        clear_counters();
        read_word(addr);
        wait_idle(20);

        chk_fails = i_dut.i_checker.fail_cnt;
        $display("errors: compare %0d, assertion %0d, timeout %0d",
                 mon_errors, chk_fails, timeouts);
        if (mon_errors == 0 && chk_fails == 0 && timeouts == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
rtl/ecc_pkg.sv
rtl/sram_pkg.sv
rtl/ecc_enc.sv
rtl/ecc_dec.sv
rtl/sram_wmask_1rw.sv
rtl/sram_wmask_ecc_1rw.sv
rtl/ecc_err_log.sv
rtl/sram_ecc_top.sv
tb/tb_sram_ecc_checker.sv
tb/tb_sram_ecc_monitor.sv
tb/tb_sram_ecc_top.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := tb_sram_ecc_top
FILELIST  := sim.f
BUILD_DIR := obj_dir
RUN_FLAGS := +verilator+error+limit+1000
PASS_MSG  := SIMULATION PASSED

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# the output is kept in a shell variable, so no log file is written
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) $(RUN_FLAGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
